//--- dc_ctrl.sv
// One request in flight; hits respond two edges after acceptance, misses fill four words one at a time
`default_nettype none

module dc_ctrl (
  input  wire                         clk,
  input  wire                         rst,
  // Processor side
  input  wire                         req_valid,
  output logic                        req_ready,
  input  wire                         req_we,
  input  wire dcache_pkg::addr_t      req_addr,
  input  wire dcache_pkg::word_t      req_wdata,
  output logic                        resp_valid,
  input  wire                         resp_ready,
  output dcache_pkg::word_t           resp_rdata,
  // Memory side
  output logic                        mem_req_valid,
  input  wire                         mem_req_ready,
  output logic                        mem_req_we,
  output dcache_pkg::addr_t           mem_req_addr,
  output dcache_pkg::word_t           mem_req_wdata,
  input  wire                         mem_resp_valid,
  input  wire dcache_pkg::word_t      mem_resp_rdata,
  // Tag store
  output dcache_pkg::index_t          tag_index,
  output logic                        tag_wr,
  output dcache_pkg::tag_entry_t      tag_new_way1,
  output dcache_pkg::tag_entry_t      tag_new_way0,
  input  wire dcache_pkg::tag_entry_t tag_entry_way1,
  input  wire dcache_pkg::tag_entry_t tag_entry_way0,
  // Data store
  output dcache_pkg::index_t          data_index,
  output dcache_pkg::offset_t         data_offset,
  output logic                        data_wr,
  output logic                        data_way,
  output dcache_pkg::word_t           data_wdata,
  input  wire dcache_pkg::word_t      data_way1,
  input  wire dcache_pkg::word_t      data_way0
);

  import dcache_pkg::*;

  // ========================================
  // State and latched request
  // ========================================
  ctrl_state_t state;
  logic        cmp_done;
  offset_t     beat;
  logic        rd_pending;
  logic [NUM_SETS-1:0] lru;

  addr_t req_addr_q;
  logic  req_we_q;
  word_t req_wdata_q;
  word_t resp_rdata_q;

  // Compare results held for the second lookup cycle
  logic  hit_q;
  logic  hit_way_q;
  logic  victim_way_q;
  logic  victim_dirty_q;
  tag_t  victim_tag_q;

  tag_t       req_tag;
  index_t     req_index;
  offset_t    req_offset;
  logic       hit_way1;
  logic       hit_way0;
  logic       victim_way;
  tag_entry_t victim_entry;
  logic       last_beat;
  word_t      fill_word;

  assign req_tag    = addr_tag(req_addr_q);
  assign req_index  = addr_index(req_addr_q);
  assign req_offset = addr_offset(req_addr_q);

  // Tag compare, valid entries only
  assign hit_way1 = entry_valid(tag_entry_way1) && (entry_tag(tag_entry_way1) == req_tag);
  assign hit_way0 = entry_valid(tag_entry_way0) && (entry_tag(tag_entry_way0) == req_tag);

  // Invalid way first, else the one the LRU bit names
  always_comb begin
    if (!entry_valid(tag_entry_way0)) begin
      victim_way = 1'b0;
    end else if (!entry_valid(tag_entry_way1)) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru[req_index];
    end
  end

  assign victim_entry = victim_way ? tag_entry_way1 : tag_entry_way0;
  assign last_beat    = (beat == offset_t'(LINE_WORDS - 1));

  // Write miss merges the store data into the fill
  assign fill_word = (req_we_q && beat == req_offset) ? req_wdata_q : mem_resp_rdata;

  // ========================================
  // FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      cmp_done   <= 1'b0;
      beat       <= '0;
      rd_pending <= 1'b0;
      lru        <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_valid) begin
            state    <= ST_LOOKUP;
            cmp_done <= 1'b0;
          end
        end
        ST_LOOKUP: begin
          // First cycle compares, second acts on the result
          if (!cmp_done) begin
            cmp_done <= 1'b1;
          end else begin
            cmp_done <= 1'b0;
            beat     <= '0;
            if (hit_q) begin
              lru[req_index] <= !hit_way_q;
              state          <= ST_RESPOND;
            end else if (victim_dirty_q) begin
              state <= ST_WRITEBACK;
            end else begin
              state <= ST_REFILL;
            end
          end
        end
        ST_WRITEBACK: begin
          if (mem_req_ready) begin
            beat <= beat + 1'b1;
            if (last_beat) begin
              state <= ST_REFILL;
            end
          end
        end
        ST_REFILL: begin
          // Issue one read, wait for its word, then the next
          if (!rd_pending) begin
            if (mem_req_ready) begin
              rd_pending <= 1'b1;
            end
          end else if (mem_resp_valid) begin
            rd_pending <= 1'b0;
            beat       <= beat + 1'b1;
            if (last_beat) begin
              lru[req_index] <= !victim_way_q;
              state          <= ST_RESPOND;
            end
          end
        end
        ST_RESPOND: begin
          if (resp_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req_valid) begin
      req_addr_q  <= req_addr;
      req_we_q    <= req_we;
      req_wdata_q <= req_wdata;
    end
    if (state == ST_LOOKUP && !cmp_done) begin
      hit_q          <= hit_way1 || hit_way0;
      hit_way_q      <= hit_way1;
      victim_way_q   <= victim_way;
      victim_dirty_q <= entry_valid(victim_entry) && entry_dirty(victim_entry);
      victim_tag_q   <= entry_tag(victim_entry);
    end
    if (state == ST_LOOKUP && cmp_done && hit_q) begin
      resp_rdata_q <= req_we_q ? req_wdata_q : (hit_way_q ? data_way1 : data_way0);
    end
    // Requested word captured as it arrives
    if (state == ST_REFILL && rd_pending && mem_resp_valid && beat == req_offset) begin
      resp_rdata_q <= fill_word;
    end
  end

  // ========================================
  // Outputs
  // ========================================
  always_comb begin
    req_ready     = (state == ST_IDLE);
    resp_valid    = (state == ST_RESPOND);
    resp_rdata    = resp_rdata_q;
    mem_req_valid = 1'b0;
    mem_req_we    = 1'b0;
    mem_req_addr  = make_addr(req_tag, req_index, beat);
    mem_req_wdata = victim_way_q ? data_way1 : data_way0;
    tag_index     = req_index;
    tag_wr        = 1'b0;
    tag_new_way1  = tag_entry_way1;
    tag_new_way0  = tag_entry_way0;
    data_index    = req_index;
    data_offset   = req_offset;
    data_wr       = 1'b0;
    data_way      = hit_way_q;
    data_wdata    = req_wdata_q;
    case (state)
      ST_LOOKUP: begin
        // Write hit stores the word and marks the line dirty
        if (cmp_done && hit_q && req_we_q) begin
          data_wr = 1'b1;
          tag_wr  = 1'b1;
          if (hit_way_q) begin
            tag_new_way1 = make_entry(1'b1, 1'b1, req_tag);
          end else begin
            tag_new_way0 = make_entry(1'b1, 1'b1, req_tag);
          end
        end
      end
      ST_WRITEBACK: begin
        mem_req_valid = 1'b1;
        mem_req_we    = 1'b1;
        mem_req_addr  = make_addr(victim_tag_q, req_index, beat);
        data_offset   = beat;
      end
      ST_REFILL: begin
        mem_req_valid = !rd_pending;
        data_offset   = beat;
        data_way      = victim_way_q;
        if (rd_pending && mem_resp_valid) begin
          data_wr    = 1'b1;
          data_wdata = fill_word;
          // New tag goes in with the last word, dirty only for a write
          if (last_beat) begin
            tag_wr = 1'b1;
            if (victim_way_q) begin
              tag_new_way1 = make_entry(1'b1, req_we_q, req_tag);
            end else begin
              tag_new_way0 = make_entry(1'b1, req_we_q, req_tag);
            end
          end
        end
      end
      default: begin
      end
    endcase
  end

  // ========================================
  // Checks
  // ========================================
  a_resp_hold: assert property (
    @(posedge clk) disable iff (rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata)
  );

  a_mem_hold: assert property (
    @(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=>
      mem_req_valid && $stable(mem_req_we) && $stable(mem_req_addr) &&
      (!mem_req_we || $stable(mem_req_wdata))
  );

  // Tag store and fill logic together must never install a duplicate
  a_single_hit: assert property (
    @(posedge clk) disable iff (rst)
    state == ST_LOOKUP |-> !(hit_way1 && hit_way0)
  );

endmodule

`default_nettype wire

//--- dc_data_store.sv
// Contents are undefined after reset; one word of one way is written per clock
`default_nettype none

module dc_data_store (
  input  wire                      clk,
  input  wire dcache_pkg::index_t  index,
  input  wire dcache_pkg::offset_t offset,
  input  wire                      wr,
  input  wire                      wr_way,
  input  wire dcache_pkg::word_t   wdata,
  output dcache_pkg::word_t        rdata_way1,
  output dcache_pkg::word_t        rdata_way0
);

  import dcache_pkg::*;

  localparam int DEPTH = NUM_SETS * LINE_WORDS;

  // ========================================
  // Word arrays, set and offset flattened
  // ========================================
  word_t way1_mem [DEPTH];
  word_t way0_mem [DEPTH];

  logic [INDEX_W+OFFSET_W-1:0] word_sel;

  // Line words sit next to each other
  assign word_sel = {index, offset};

  // Only the selected way takes the word
  always_ff @(posedge clk) begin
    if (wr && wr_way) begin
      way1_mem[word_sel] <= wdata;
    end
    if (wr && !wr_way) begin
      way0_mem[word_sel] <= wdata;
    end
  end

  // Same word of both ways, controller picks
  assign rdata_way1 = way1_mem[word_sel];
  assign rdata_way0 = way0_mem[word_sel];

  // ========================================
  // Checks
  // ========================================
  // Offset comes from the beat counter during fills
  a_offset_known: assert property (
    @(posedge clk)
    wr |-> !$isunknown(offset)
  );

endmodule

`default_nettype wire

//--- dc_tag_store.sv
// Read is combinational on index; both ways of a set are written together and rst clears every entry
`default_nettype none

module dc_tag_store (
  input  wire                         clk,
  input  wire                         rst,
  input  wire dcache_pkg::index_t     index,
  input  wire                         wr,
  input  wire dcache_pkg::tag_entry_t entry_in_way1,
  input  wire dcache_pkg::tag_entry_t entry_in_way0,
  output dcache_pkg::tag_entry_t      entry_out_way1,
  output dcache_pkg::tag_entry_t      entry_out_way0
);

  import dcache_pkg::*;

  // ========================================
  // Entry arrays, one per way
  // ========================================
  tag_entry_t way1_q [NUM_SETS];
  tag_entry_t way0_q [NUM_SETS];

  // Clear valid and dirty on reset, else write the whole set
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_SETS; i++) begin
        way1_q[i] <= '0;
        way0_q[i] <= '0;
      end
    end else if (wr) begin
      way1_q[index] <= entry_in_way1;
      way0_q[index] <= entry_in_way0;
    end
  end

  // Both ways visible in the same cycle for the tag compare
  assign entry_out_way1 = way1_q[index];
  assign entry_out_way0 = way0_q[index];

  // ========================================
  // Checks
  // ========================================
  // A write with an unknown set would corrupt an arbitrary entry
  a_index_known: assert property (
    @(posedge clk) disable iff (rst)
    wr |-> !$isunknown(index)
  );

endmodule

`default_nettype wire

//--- dcache_pkg.sv
// Geometry is fixed at 2 ways, 16 sets and 4 words per line with 20-bit word addresses; no byte enables
`default_nettype none

package dcache_pkg;

  // ========================================
  // Widths and geometry
  // ========================================
  localparam int WORD_W   = 16;
  localparam int ADDR_W   = 20;
  localparam int TAG_W    = 14;
  localparam int INDEX_W  = 4;
  localparam int OFFSET_W = 2;
  localparam int ENTRY_W  = 16;

  localparam int NUM_SETS   = 16;
  localparam int LINE_WORDS = 4;

  // Tag entry layout: valid on top, dirty below it, tag in the low bits
  localparam int ENTRY_VALID_BIT = 15;
  localparam int ENTRY_DIRTY_BIT = 14;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [ENTRY_W-1:0]  tag_entry_t;

  // Controller FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL,
    ST_RESPOND
  } ctrl_state_t;

  // ========================================
  // Address and entry helpers
  // ========================================
  function automatic tag_t addr_tag(addr_t a);
    return a[ADDR_W-1:INDEX_W+OFFSET_W];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[INDEX_W+OFFSET_W-1:OFFSET_W];
  endfunction

  function automatic offset_t addr_offset(addr_t a);
    return a[OFFSET_W-1:0];
  endfunction

  function automatic addr_t make_addr(tag_t t, index_t i, offset_t o);
    return {t, i, o};
  endfunction

  function automatic logic entry_valid(tag_entry_t e);
    return e[ENTRY_VALID_BIT];
  endfunction

  function automatic logic entry_dirty(tag_entry_t e);
    return e[ENTRY_DIRTY_BIT];
  endfunction

  function automatic tag_t entry_tag(tag_entry_t e);
    return e[TAG_W-1:0];
  endfunction

  function automatic tag_entry_t make_entry(logic v, logic d, tag_t t);
    tag_entry_t e;
    e = '0;
    e[ENTRY_VALID_BIT] = v;
    e[ENTRY_DIRTY_BIT] = d;
    e[TAG_W-1:0] = t;
    return e;
  endfunction

endpackage

`default_nettype wire

//--- dcache_top.sv
// Memory side must return read data exactly one cycle after each read transfer
`default_nettype none

module dcache_top (
  input  wire                    clk,
  input  wire                    rst,
  // Processor request and response
  input  wire                    req_valid,
  output wire                    req_ready,
  input  wire                    req_we,
  input  wire dcache_pkg::addr_t req_addr,
  input  wire dcache_pkg::word_t req_wdata,
  output wire                    resp_valid,
  input  wire                    resp_ready,
  output dcache_pkg::word_t      resp_rdata,
  // Memory, one word per transfer
  output wire                    mem_req_valid,
  input  wire                    mem_req_ready,
  output wire                    mem_req_we,
  output dcache_pkg::addr_t      mem_req_addr,
  output dcache_pkg::word_t      mem_req_wdata,
  input  wire                    mem_resp_valid,
  input  wire dcache_pkg::word_t mem_resp_rdata
);

  import dcache_pkg::*;

  // ========================================
  // Store connections
  // ========================================
  index_t     tag_index;
  logic       tag_wr;
  tag_entry_t tag_new_way1;
  tag_entry_t tag_new_way0;
  tag_entry_t tag_entry_way1;
  tag_entry_t tag_entry_way0;

  index_t     data_index;
  offset_t    data_offset;
  logic       data_wr;
  logic       data_way;
  word_t      data_wdata;
  word_t      data_way1;
  word_t      data_way0;

  // Controller
  dc_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_we         (req_we),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_rdata     (resp_rdata),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_we     (mem_req_we),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata),
    .tag_index      (tag_index),
    .tag_wr         (tag_wr),
    .tag_new_way1   (tag_new_way1),
    .tag_new_way0   (tag_new_way0),
    .tag_entry_way1 (tag_entry_way1),
    .tag_entry_way0 (tag_entry_way0),
    .data_index     (data_index),
    .data_offset    (data_offset),
    .data_wr        (data_wr),
    .data_way       (data_way),
    .data_wdata     (data_wdata),
    .data_way1      (data_way1),
    .data_way0      (data_way0)
  );

  // Valid, dirty and tag per way
  dc_tag_store u_tag_store (
    .clk            (clk),
    .rst            (rst),
    .index          (tag_index),
    .wr             (tag_wr),
    .entry_in_way1  (tag_new_way1),
    .entry_in_way0  (tag_new_way0),
    .entry_out_way1 (tag_entry_way1),
    .entry_out_way0 (tag_entry_way0)
  );

  // Line words, no reset
  dc_data_store u_data_store (
    .clk        (clk),
    .index      (data_index),
    .offset     (data_offset),
    .wr         (data_wr),
    .wr_way     (data_way),
    .wdata      (data_wdata),
    .rdata_way1 (data_way1),
    .rdata_way0 (data_way0)
  );

endmodule

`default_nettype wire

//--- project.f
dcache_pkg.sv
dc_tag_store.sv
dc_data_store.sv
dc_ctrl.sv
dcache_top.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run the cache testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f project.f \
  --top-module tb_dcache -o sim_dcache > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tb_clk_gen.sv
// Free-running 40 ns clock; rst is held high for the first 10 rising edges
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    rst = 1'b1;
  end

  // Half period of 20 ns
  always #20 clk = ~clk;

  initial begin
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_dcache.sv
// Runs one request at a time; shadow memory and shadow tags predict data, hits and memory traffic
`default_nettype none

module tb_dcache;

  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  localparam int TIMEOUT = 400;

  // ========================================
  // DUT signals
  // ========================================
  logic  clk;
  logic  rst;
  logic  req_valid;
  logic  req_ready;
  logic  req_we;
  addr_t req_addr;
  word_t req_wdata;
  logic  resp_valid;
  logic  resp_ready;
  word_t resp_rdata;
  logic  mem_req_valid;
  logic  mem_req_ready;
  logic  mem_req_we;
  addr_t mem_req_addr;
  word_t mem_req_wdata;
  logic  mem_resp_valid;
  word_t mem_resp_rdata;

  tb_clk_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  dcache_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_we         (req_we),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_rdata     (resp_rdata),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_we     (mem_req_we),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata)
  );

  tb_mem_model u_mem (
    .clk            (clk),
    .rst            (rst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_we     (mem_req_we),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata)
  );

  // ========================================
  // Shadow state
  // ========================================
  word_t shadow_mem [0:(1<<ADDR_W)-1];
  logic  sh_valid [NUM_SETS][2];
  logic  sh_dirty [NUM_SETS][2];
  tag_t  sh_tag [NUM_SETS][2];
  logic  sh_lru [NUM_SETS];

  // Expected outcome of the request in flight
  logic   pred_hit;
  word_t  exp_rdata;
  int     exp_wr_cnt;
  int     exp_rd_cnt;
  int     wr_cnt;
  int     rd_cnt;
  integer seed;

  function automatic word_t preset_word(addr_t a);
    return a[15:0] ^ {a[19:16], a[3:0], a[19:16], a[7:4]} ^ 16'ha5c3;
  endfunction

  function automatic addr_t addr_of(int t, int s, int o);
    return {t[13:0], s[3:0], o[1:0]};
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  // Hit, victim and LRU follow the replacement rule
  task automatic predict(input logic we, input addr_t a, input word_t d);
    tag_t   t;
    int     s;
    int     way;
    logic   victim;
    t = a[19:6];
    s = int'(a[5:2]);
    way = -1;
    if (sh_valid[s][0] && sh_tag[s][0] == t) way = 0;
    if (sh_valid[s][1] && sh_tag[s][1] == t) way = 1;
    exp_rdata = we ? d : shadow_mem[a];
    if (way >= 0) begin
      pred_hit   = 1'b1;
      exp_wr_cnt = 0;
      exp_rd_cnt = 0;
      if (we) sh_dirty[s][way] = 1'b1;
      sh_lru[s] = (way == 0);
    end else begin
      pred_hit = 1'b0;
      if (!sh_valid[s][0]) victim = 1'b0;
      else if (!sh_valid[s][1]) victim = 1'b1;
      else victim = sh_lru[s];
      exp_wr_cnt = (sh_valid[s][victim] && sh_dirty[s][victim]) ? LINE_WORDS : 0;
      exp_rd_cnt = LINE_WORDS;
      sh_valid[s][victim] = 1'b1;
      sh_dirty[s][victim] = we;
      sh_tag[s][victim]   = t;
      sh_lru[s]           = !victim;
    end
  endtask

  // One request and its response
  // A positive hold keeps resp_ready low for that many cycles
  task automatic access(input logic we, input addr_t a, input word_t d, input int hold);
    int t;
    @(posedge clk);
    predict(we, a, d);
    req_valid <= 1'b1;
    req_we    <= we;
    req_addr  <= a;
    req_wdata <= d;
    if (hold > 0) resp_ready <= 1'b0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) stop_run("Timeout: request was never accepted");
    end while (!req_ready);
    @(posedge clk);
    req_valid <= 1'b0;
    if (we) shadow_mem[a] = d;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) stop_run("Timeout: no response from the cache");
    end while (!resp_valid);
    if (hold > 0) begin
      repeat (hold) @(posedge clk);
      resp_ready <= 1'b1;
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  // Memory transfers seen during the current request
  always @(posedge clk) begin
    if (req_valid && req_ready) begin
      wr_cnt <= 0;
      rd_cnt <= 0;
    end else if (mem_req_valid && mem_req_ready) begin
      if (mem_req_we) wr_cnt <= wr_cnt + 1;
      else rd_cnt <= rd_cnt + 1;
    end
  end

  // ========================================
  // Checks
  // ========================================
  a_resp_data: assert property (@(posedge clk) disable iff (rst)
    resp_valid && resp_ready |-> resp_rdata == exp_rdata)
    else stop_run($sformatf("** Error at %0d ns: response %h, expected %h",
                            $time, $sampled(resp_rdata), exp_rdata));

  a_mem_counts: assert property (@(posedge clk) disable iff (rst)
    resp_valid && resp_ready |-> wr_cnt == exp_wr_cnt && rd_cnt == exp_rd_cnt)
    else stop_run($sformatf("** Error at %0d ns: %0d writes %0d reads, expected %0d and %0d",
                            $time, wr_cnt, rd_cnt, exp_wr_cnt, exp_rd_cnt));

  // Hit responds two edges after the transfer edge
  a_hit_latency: assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready && pred_hit |=> !resp_valid ##1 !resp_valid ##1 resp_valid)
    else stop_run($sformatf("** Error at %0d ns: hit response not two edges after request",
                            $time));

  a_writeback_data: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && mem_req_ready && mem_req_we |-> mem_req_wdata == shadow_mem[mem_req_addr])
    else stop_run($sformatf("** Error at %0d ns: writeback of %h has wrong data",
                            $time, $sampled(mem_req_addr)));

  a_resp_hold: assert property (@(posedge clk) disable iff (rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
    else stop_run($sformatf("** Error at %0d ns: response dropped or changed while held",
                            $time));

  a_ready_low: assert property (@(posedge clk) disable iff (rst)
    resp_valid |-> !req_ready)
    else stop_run($sformatf("** Error at %0d ns: req_ready high during response", $time));

  a_reset_state: assert property (@(posedge clk)
    $fell(rst) |-> req_ready && !resp_valid && !mem_req_valid)
    else stop_run($sformatf("** Error at %0d ns: wrong outputs after reset", $time));

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    int    t;
    int    r;
    addr_t a;
    seed       = 8;
    req_valid  = 1'b0;
    req_we     = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    resp_ready = 1'b1;
    pred_hit   = 1'b0;
    exp_rdata  = '0;
    exp_wr_cnt = 0;
    exp_rd_cnt = 0;
    wr_cnt     = 0;
    rd_cnt     = 0;
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      shadow_mem[i] = preset_word(addr_t'(i));
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      sh_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        sh_valid[s][w] = 1'b0;
        sh_dirty[s][w] = 1'b0;
        sh_tag[s][w]   = '0;
      end
    end

    t = 0;
    while (rst) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) stop_run("Timeout: reset never released");
    end

    // First read fills from the preset, then hits in the same line
    access(1'b0, addr_of(3, 2, 1), '0, 0);
    access(1'b0, addr_of(3, 2, 3), '0, 0);

    // Write hit then read back
    access(1'b1, addr_of(3, 2, 0), 16'h1234, 0);
    access(1'b0, addr_of(3, 2, 0), '0, 0);

    // Three written tags in one set force a dirty eviction
    access(1'b1, addr_of(10, 5, 2), 16'hbeef, 0);
    access(1'b1, addr_of(11, 5, 0), 16'hcafe, 0);
    access(1'b1, addr_of(12, 5, 3), 16'h0f0f, 0);
    access(1'b0, addr_of(10, 5, 2), '0, 0);

    // Clean lines leave without memory writes
    access(1'b0, addr_of(20, 6, 0), '0, 0);
    access(1'b0, addr_of(21, 6, 1), '0, 0);
    access(1'b0, addr_of(22, 6, 2), '0, 0);

    // Response held off by the processor
    access(1'b0, addr_of(21, 6, 3), '0, 6);
    access(1'b0, addr_of(40, 7, 2), '0, 5);

    // Random mix over four sets and three tags
    for (int n = 0; n < 300; n++) begin
      r = $random(seed);
      a = addr_of(int'(r[9:8]) % 3 + 30, int'(r[1:0]), int'(r[3:2]));
      access(r[4], a, r[31:16], 0);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
// Full 2^20-word memory behind the cache; read data comes back one cycle after each read transfer
`default_nettype none

module tb_mem_model (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    mem_req_valid,
  output logic                   mem_req_ready,
  input  wire                    mem_req_we,
  input  wire dcache_pkg::addr_t mem_req_addr,
  input  wire dcache_pkg::word_t mem_req_wdata,
  output logic                   mem_resp_valid,
  output dcache_pkg::word_t      mem_resp_rdata
);

  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  // ========================================
  // Storage and preset
  // ========================================
  word_t  mem [0:(1<<ADDR_W)-1];
  integer seed;
  logic   fire;

  // Every address bit takes part in the preset word
  function automatic word_t preset_word(addr_t a);
    return a[15:0] ^ {a[19:16], a[3:0], a[19:16], a[7:4]} ^ 16'ha5c3;
  endfunction

  initial begin
    seed           = 8;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_rdata = '0;
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      mem[i] = preset_word(addr_t'(i));
    end
  end

  assign fire = mem_req_valid && mem_req_ready;

  // ========================================
  // Transfer handling
  // ========================================
  always @(posedge clk) begin
    if (rst) begin
      mem_req_ready  <= 1'b0;
      mem_resp_valid <= 1'b0;
    end else begin
      // Ready about three cycles out of four
      mem_req_ready  <= ($random(seed) & 3) != 0;
      mem_resp_valid <= fire && !mem_req_we;
      if (fire && !mem_req_we) begin
        mem_resp_rdata <= mem[mem_req_addr];
      end
      if (fire && mem_req_we) begin
        mem[mem_req_addr] <= mem_req_wdata;
      end
    end
  end

endmodule

`default_nettype wire
